//--- Makefile
.PHONY: all run lint clean

all: run

obj_dir/Vtb_pocket_core: project.f $(wildcard *.sv)
	verilator --binary --timing --assert -f project.f --top-module tb_pocket_core \
		-o Vtb_pocket_core

run: obj_dir/Vtb_pocket_core
	./obj_dir/Vtb_pocket_core > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi

lint:
	verilator --lint-only --timing -Wall -f project.f --top-module tb_pocket_core

clean:
	rm -rf obj_dir sim.log

//--- bridge_pkg.sv
////////////////////////////////////////////////////////////
// bridge side definitions for the core top level
// addresses, save buffer sizes and the settings record
////////////////////////////////////////////////////////////

package bridge_pkg;

  // bridge bus as the core sees it, all on clk_74a
  typedef struct packed {
    logic [31:0] addr;
    logic        rd;
    logic        wr;
    logic [31:0] wr_data;
  } bridge_req_t;

  ////////////////////////////////////////////////////////////
  // write decoder addresses

  localparam logic [31:0] addr_cart_download = 32'h0000_0000;
  localparam logic [31:0] addr_is_color_cart = 32'h0000_0004;
  localparam logic [31:0] addr_bw_bios       = 32'h0000_0008;
  localparam logic [31:0] addr_color_bios    = 32'h0000_000C;
  localparam logic [31:0] addr_save_download = 32'h0000_0010;

  localparam logic [31:0] addr_reset         = 32'h0000_0050;
  localparam logic [31:0] addr_system        = 32'h0000_0100;
  localparam logic [31:0] addr_cpu_turbo     = 32'h0000_0110;

  localparam logic [31:0] addr_triple_buffer = 32'h0000_0200;
  localparam logic [31:0] addr_flickerblend  = 32'h0000_0204;
  localparam logic [31:0] addr_orientation   = 32'h0000_0208;
  localparam logic [31:0] addr_flip_h        = 32'h0000_020C;

  localparam logic [31:0] addr_ff_sound      = 32'h0000_0300;

  // save region is picked by the top address nibble
  localparam logic [3:0] save_region_nibble = 4'h2;

  localparam int save_addr_width = 10;
  localparam int save_data_width = 16;

  // external reset hold time, in clk_74a cycles
  localparam int reset_hold_cycles = 256;
  localparam int reset_count_width = $clog2(reset_hold_cycles + 1);

  typedef enum logic [1:0] {
    orient_auto       = 2'd0,
    orient_horizontal = 2'd1,
    orient_vertical   = 2'd2
  } orientation_e;

  typedef struct packed {
    logic [1:0]   system;
    logic         cpu_turbo;
    logic         triple_buffer;
    logic [1:0]   flickerblend;
    orientation_e orientation;
    logic         flip_h;
    logic         ff_sound;
    // download flags
    logic         cart_download;
    logic         is_color_cart;
    logic         bw_bios;
    logic         color_bios;
    logic         save_download;
  } core_settings_t;

  // one halfword access toward the save RAM
  typedef struct packed {
    logic                       valid;
    logic                       write;
    logic [save_addr_width-1:0] addr;
    logic [save_data_width-1:0] data;
  } save_req_t;

endpackage

//--- core_trace.txt
# W addr data | R addr expected_word | S expected_settings (hex)
# V orientation_code is_vertical expected_slot_bit (decimal)
W 00000004 00000001
W 00000100 00000003
W 00000110 00000001
W 00000200 00000001
W 00000204 00000002
W 00000208 00000002
W 0000020C 00000001
W 00000300 00000001
W 00000010 00000001
W 00000404 FFFFFFFF
S 00007D69
W 00000050 00000001
W 20000000 12345678
W 20000004 CAFEF00D
W 00000208 00000000
R 20000000 12345678
R 20000004 CAFEF00D
R 00000104 00000000
W 200003FC A5A55A5A
R 200003FC A5A55A5A
V 0 0 0
V 0 1 1
V 1 1 0
V 2 0 1
S 00007D69

//--- pocket_core.sv
////////////////////////////////////////////////////////////
// host facing top level of the core on clk_74a
// settings, save buffer, bridge read mux and video output
////////////////////////////////////////////////////////////

module pocket_core (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  bridge_pkg::bridge_req_t    bridge,
  input  video_pkg::video_in_t       video_in,
  input  logic                       is_vertical,
  output logic [31:0]                bridge_rd_data,
  output bridge_pkg::core_settings_t settings,
  output logic                       external_reset,
  output video_pkg::video_out_t      video_out
);

  bridge_pkg::save_req_t                  load_req;
  bridge_pkg::save_req_t                  unload_req;
  logic                                   load_grant;
  logic                                   unload_grant;
  logic [bridge_pkg::save_data_width-1:0] ram_data;
  logic [31:0]                            save_rd_word;

  settings_regs i_settings_regs (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .settings        (settings),
    .external_reset  (external_reset)
  );

  ////////////////////////////////////////////////////////////
  // save buffer

  save_loader i_save_loader (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .req             (load_req),
    .grant           (load_grant)
  );

  save_unloader i_save_unloader (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .req             (unload_req),
    .grant           (unload_grant),
    .ram_data        (ram_data),
    .rd_word         (save_rd_word)
  );

  save_ram_arbiter i_save_ram_arbiter (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .load_req        (load_req),
    .unload_req      (unload_req),
    .load_grant      (load_grant),
    .unload_grant    (unload_grant),
    .ram_data        (ram_data)
  );

  // bridge reads, only the save region answers
  always_comb begin
    if (bridge.addr[31:28] == bridge_pkg::save_region_nibble) begin
      bridge_rd_data = save_rd_word;
    end else begin
      bridge_rd_data = '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // video

  video_conditioner i_video_conditioner (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .video_in        (video_in),
    .is_vertical     (is_vertical),
    .orientation     (settings.orientation),
    .video_out       (video_out)
  );

endmodule

//--- pocket_core_assertions.sv
////////////////////////////////////////////////////////////
// concurrent checks on the video sync pulses and the
// save RAM grants, attached to the design with bind
////////////////////////////////////////////////////////////

module pocket_core_assertions #(
  parameter bit check_pulses    = 1'b0,
  parameter bit check_exclusive = 1'b0
) (
  input logic clk_74a,
  input logic pll_core_locked,
  input logic first,
  input logic second
);

  timeunit 1ns;
  timeprecision 100ps;

  // sync outputs are single cycle pulses
  first_single : assert property (@(posedge clk_74a)
    disable iff (!pll_core_locked || !check_pulses) first |=> !first)
    else $error("first pulse stayed high for two cycles");

  second_single : assert property (@(posedge clk_74a)
    disable iff (!pll_core_locked || !check_pulses) second |=> !second)
    else $error("second pulse stayed high for two cycles");

  // one grant per cycle
  one_grant : assert property (@(posedge clk_74a)
    disable iff (!pll_core_locked || !check_exclusive) !(first && second))
    else $error("both save RAM grants high in the same cycle");

endmodule

bind video_conditioner pocket_core_assertions #(.check_pulses(1'b1)) i_sync_assertions (
  .clk_74a         (clk_74a),
  .pll_core_locked (pll_core_locked),
  .first           (video_out.hs),
  .second          (video_out.vs)
);

bind save_ram_arbiter pocket_core_assertions #(.check_exclusive(1'b1)) i_grant_assertions (
  .clk_74a         (clk_74a),
  .pll_core_locked (pll_core_locked),
  .first           (load_grant),
  .second          (unload_grant)
);

//--- project.f
bridge_pkg.sv
video_pkg.sv
settings_regs.sv
save_loader.sv
save_unloader.sv
save_ram_arbiter.sv
video_conditioner.sv
pocket_core.sv
pocket_core_assertions.sv
tb_checker.sv
tb_pocket_core.sv

//--- save_loader.sv
////////////////////////////////////////////////////////////
// splits a 32-bit bridge write in the save region into
// two halfword writes, high half to the even address first
////////////////////////////////////////////////////////////

module save_loader (
  input  logic                    clk_74a,
  input  logic                    pll_core_locked,
  input  bridge_pkg::bridge_req_t bridge,
  output bridge_pkg::save_req_t   req,
  input  logic                    grant
);

  typedef enum logic [1:0] {
    load_idle,
    load_high,
    load_low
  } load_state_e;

  load_state_e state;

  // halfword pair base, bit 0 comes from the state
  logic [bridge_pkg::save_addr_width-2:0] base_addr;
  logic [bridge_pkg::save_data_width-1:0] high_half;
  logic [bridge_pkg::save_data_width-1:0] low_half;
  logic                                   save_wr;

  assign save_wr = bridge.wr && (bridge.addr[31:28] == bridge_pkg::save_region_nibble);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state <= load_idle;
    end else begin
      case (state)
        load_idle: begin
          if (save_wr) begin
            state <= load_high;
          end
        end
        load_high: begin
          if (grant) begin
            state <= load_low;
          end
        end
        default: begin
          if (grant) begin
            state <= load_idle;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_74a) begin
    if (state == load_idle && save_wr) begin
      base_addr <= bridge.addr[bridge_pkg::save_addr_width:2];
      high_half <= bridge.wr_data[31:16];
      low_half  <= bridge.wr_data[15:0];
    end
  end

  // big endian, even halfword carries bits 31:16
  always_comb begin
    req.valid = (state != load_idle);
    req.write = 1'b1;
    req.addr  = {base_addr, state == load_low};
    req.data  = (state == load_low) ? low_half : high_half;
  end

endmodule

//--- save_ram_arbiter.sv
////////////////////////////////////////////////////////////
// save RAM shared by the loader and the unloader
// one grant per cycle, loader writes go first
////////////////////////////////////////////////////////////

module save_ram_arbiter (
  input  logic                                   clk_74a,
  input  logic                                   pll_core_locked,
  input  bridge_pkg::save_req_t                  load_req,
  input  bridge_pkg::save_req_t                  unload_req,
  output logic                                   load_grant,
  output logic                                   unload_grant,
  output logic [bridge_pkg::save_data_width-1:0] ram_data
);

  logic [bridge_pkg::save_data_width-1:0] mem [0:(1 << bridge_pkg::save_addr_width)-1];

  bridge_pkg::save_req_t sel_req;

  // fixed priority, the unloader waits while a write is pending
  assign load_grant   = load_req.valid;
  assign unload_grant = unload_req.valid && !load_req.valid;

  assign sel_req = load_grant ? load_req : unload_req;

  always_ff @(posedge clk_74a) begin
    if (sel_req.valid && sel_req.write) begin
      mem[sel_req.addr] <= sel_req.data;
    end
  end

  // synchronous read, held until the next granted read
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      ram_data <= '0;
    end else if (sel_req.valid && !sel_req.write) begin
      ram_data <= mem[sel_req.addr];
    end
  end

endmodule

//--- save_unloader.sv
////////////////////////////////////////////////////////////
// answers a bridge read in the save region with two
// halfword reads and keeps the assembled 32-bit word
////////////////////////////////////////////////////////////

module save_unloader (
  input  logic                                   clk_74a,
  input  logic                                   pll_core_locked,
  input  bridge_pkg::bridge_req_t                bridge,
  output bridge_pkg::save_req_t                  req,
  input  logic                                   grant,
  input  logic [bridge_pkg::save_data_width-1:0] ram_data,
  output logic [31:0]                            rd_word
);

  typedef enum logic [1:0] {
    unload_idle,
    unload_high,
    unload_low,
    unload_done
  } unload_state_e;

  unload_state_e state;

  logic [bridge_pkg::save_addr_width-2:0] base_addr;
  logic                                   save_rd;

  assign save_rd = bridge.rd && (bridge.addr[31:28] == bridge_pkg::save_region_nibble);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      state <= unload_idle;
    end else begin
      case (state)
        unload_idle: begin
          if (save_rd) begin
            state <= unload_high;
          end
        end
        unload_high: begin
          if (grant) begin
            state <= unload_low;
          end
        end
        unload_low: begin
          if (grant) begin
            state <= unload_done;
          end
        end
        default: begin
          state <= unload_idle;
        end
      endcase
    end
  end

  // the RAM keeps its read data until the next granted read,
  // so the even half is still there when the odd read is granted
  always_ff @(posedge clk_74a) begin
    if (state == unload_idle && save_rd) begin
      base_addr <= bridge.addr[bridge_pkg::save_addr_width:2];
    end
    if (state == unload_low && grant) begin
      rd_word[31:16] <= ram_data;
    end
    if (state == unload_done) begin
      rd_word[15:0] <= ram_data;
    end
  end

  always_comb begin
    req.valid = (state == unload_high) || (state == unload_low);
    req.write = 1'b0;
    req.addr  = {base_addr, state == unload_low};
    req.data  = '0;
  end

endmodule

//--- settings_regs.sv
////////////////////////////////////////////////////////////
// settings register file written by the bridge
// also holds the external reset countdown
////////////////////////////////////////////////////////////

module settings_regs (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  bridge_pkg::bridge_req_t    bridge,
  output bridge_pkg::core_settings_t settings,
  output logic                       external_reset
);

  logic [bridge_pkg::reset_count_width-1:0] reset_count;

  // held high until the countdown drains
  assign external_reset = (reset_count != '0);

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings    <= '0;
      reset_count <= '0;
    end else begin
      if (reset_count != '0) begin
        reset_count <= reset_count - 1'b1;
      end

      if (bridge.wr) begin
        case (bridge.addr)
          bridge_pkg::addr_cart_download: begin
            settings.cart_download <= bridge.wr_data[0];
          end
          bridge_pkg::addr_is_color_cart: begin
            settings.is_color_cart <= bridge.wr_data[0];
          end
          bridge_pkg::addr_bw_bios: begin
            settings.bw_bios <= bridge.wr_data[0];
          end
          bridge_pkg::addr_color_bios: begin
            settings.color_bios <= bridge.wr_data[0];
          end
          bridge_pkg::addr_save_download: begin
            settings.save_download <= bridge.wr_data[0];
          end
          // restart the hold time on every write
          bridge_pkg::addr_reset: begin
            reset_count <= bridge_pkg::reset_count_width'(bridge_pkg::reset_hold_cycles);
          end
          bridge_pkg::addr_system: begin
            settings.system <= bridge.wr_data[1:0];
          end
          bridge_pkg::addr_cpu_turbo: begin
            settings.cpu_turbo <= bridge.wr_data[0];
          end
          bridge_pkg::addr_triple_buffer: begin
            settings.triple_buffer <= bridge.wr_data[0];
          end
          bridge_pkg::addr_flickerblend: begin
            settings.flickerblend <= bridge.wr_data[1:0];
          end
          bridge_pkg::addr_orientation: begin
            settings.orientation <= bridge_pkg::orientation_e'(bridge.wr_data[1:0]);
          end
          bridge_pkg::addr_flip_h: begin
            settings.flip_h <= bridge.wr_data[0];
          end
          bridge_pkg::addr_ff_sound: begin
            settings.ff_sound <= bridge.wr_data[0];
          end
          default: begin
            // other addresses are not settings
          end
        endcase
      end
    end
  end

endmodule

//--- tb_checker.sv
////////////////////////////////////////////////////////////
// checker for the core testbench, samples on the falling
// edge, models the video output and compares all results
////////////////////////////////////////////////////////////

module tb_checker (
  input  logic                       clk_74a,
  input  logic                       pll_core_locked,
  input  bridge_pkg::bridge_req_t    bridge,
  input  video_pkg::video_in_t       video_in,
  input  logic [31:0]                bridge_rd_data,
  input  bridge_pkg::core_settings_t settings,
  input  logic                       external_reset,
  input  video_pkg::video_out_t      video_out,
  input  logic                       check_stb,
  input  logic [7:0]                 check_kind,
  input  logic [127:0]               test_name,
  input  logic [31:0]                exp_value,
  input  logic                       video_active,
  input  logic                       slot_bit,
  input  logic                       done,
  output int                         tests_run,
  output int                         tests_failed
);

  timeunit 1ns;
  timeprecision 100ps;

  // p1 was sampled by the last rising edge, p2 by the one before
  video_pkg::video_in_t  p1;
  video_pkg::video_in_t  p2;
  video_pkg::video_out_t exp_out;
  logic [6:0]            rise_hist;
  logic                  active_prev;
  int                    video_errors;
  logic                  reset_watch;
  int                    reset_high;
  logic                  done_seen;

  function automatic video_pkg::video_out_t expected_video(
    input video_pkg::video_in_t cur,
    input video_pkg::video_in_t prev,
    input logic                 hs_due,
    input logic                 slot
  );
    video_pkg::video_out_t v;
    logic                  cur_de;
    logic                  prev_de;
    cur_de  = ~(cur.hblank | cur.vblank);
    prev_de = ~(prev.hblank | prev.vblank);
    v.de    = cur_de;
    v.vs    = cur.vsync && !prev.vsync;
    v.hs    = hs_due;
    v.rgb   = '0;
    if (cur_de) begin
      v.rgb = cur.rgb;
    end else if (prev_de) begin
      v.rgb[video_pkg::slot_orientation_bit] = slot;
    end
    return v;
  endfunction

  task automatic finish_test(input logic [127:0] name, input int errors);
    tests_run++;
    if (errors == 0) begin
      $display("test %0s ok", name);
    end else begin
      tests_failed++;
      $display("test %0s failed with %0d mismatches", name, errors);
    end
  endtask

  task automatic compare_word(input logic [127:0] name, input logic [31:0] exp_v,
                              input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("[ERROR] %0s expected %h actual %h", name, exp_v, act_v);
      finish_test(name, 1);
    end else begin
      finish_test(name, 0);
    end
  endtask

  always @(negedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      p1           = '0;
      p2           = '0;
      rise_hist    = '0;
      active_prev  = 1'b0;
      video_errors = 0;
      reset_watch  = 1'b0;
      reset_high   = 0;
      done_seen    = 1'b0;
      tests_run    = 0;
      tests_failed = 0;
    end else begin
      // hs shows up 7 edges after the edge that saw hsync rise
      if (video_active) begin
        exp_out = expected_video(p1, p2, rise_hist[6], slot_bit);
        if (video_out !== exp_out) begin
          video_errors++;
          $display("[ERROR] %0s video_out expected %h actual %h", test_name, exp_out,
                   video_out);
        end
      end
      if (active_prev && !video_active) begin
        finish_test(test_name, video_errors);
        video_errors = 0;
      end
      active_prev = video_active;
      rise_hist   = {rise_hist[5:0], p1.hsync && !p2.hsync};
      p2          = p1;
      p1          = video_in;

      if (check_stb) begin
        if (check_kind == "R") begin
          compare_word(test_name, exp_value, bridge_rd_data);
        end else begin
          compare_word(test_name, {17'h0, exp_value[14:0]}, {17'h0, settings});
        end
      end

      ////////////////////////////////////////////////////////////
      // external reset length
      if (bridge.wr && bridge.addr == bridge_pkg::addr_reset) begin
        reset_watch = 1'b1;
        reset_high  = 0;
      end else if (reset_watch) begin
        if (external_reset) begin
          reset_high++;
        end else begin
          reset_watch = 1'b0;
          compare_word("external_reset", 32'(bridge_pkg::reset_hold_cycles),
                       32'(reset_high));
        end
      end

      if (done && !done_seen) begin
        done_seen = 1'b1;
        $display("tests run %0d, failed %0d", tests_run, tests_failed);
      end
    end
  end

endmodule

//--- tb_pocket_core.sv
////////////////////////////////////////////////////////////
// testbench top for the core: clock, reset, trace reader,
// bridge and video stimulus, watchdog and the DUT
////////////////////////////////////////////////////////////

module tb_pocket_core;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int line_cycles   = 32;
  localparam int active_cycles = 20;
  localparam int frame_lines   = 8;
  localparam int tail_cycles   = 12;
  localparam int frame_cycles  = frame_lines * line_cycles + tail_cycles;

  logic                       clk_74a = 1'b0;
  logic                       pll_core_locked;
  bridge_pkg::bridge_req_t    bridge;
  video_pkg::video_in_t       video_in;
  logic                       is_vertical;
  logic [31:0]                bridge_rd_data;
  bridge_pkg::core_settings_t settings;
  logic                       external_reset;
  video_pkg::video_out_t      video_out;

  // checker control
  logic         check_stb;
  logic [7:0]   check_kind;
  logic [127:0] test_name;
  logic [31:0]  exp_value;
  logic         video_active;
  logic         slot_bit;
  logic         done;
  int           tests_run;
  int           tests_failed;

  // trace records
  logic [7:0]  rec_kind [$];
  logic [31:0] rec_a [$];
  logic [31:0] rec_b [$];
  int          rec_c [$];
  bit          trace_loaded = 1'b0;
  int          limit_cycles;
  int          seed;

  always #4 clk_74a = ~clk_74a;

  pocket_core i_pocket_core (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .video_in        (video_in),
    .is_vertical     (is_vertical),
    .bridge_rd_data  (bridge_rd_data),
    .settings        (settings),
    .external_reset  (external_reset),
    .video_out       (video_out)
  );

  tb_checker i_tb_checker (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .bridge          (bridge),
    .video_in        (video_in),
    .bridge_rd_data  (bridge_rd_data),
    .settings        (settings),
    .external_reset  (external_reset),
    .video_out       (video_out),
    .check_stb       (check_stb),
    .check_kind      (check_kind),
    .test_name       (test_name),
    .exp_value       (exp_value),
    .video_active    (video_active),
    .slot_bit        (slot_bit),
    .done            (done),
    .tests_run       (tests_run),
    .tests_failed    (tests_failed)
  );

  task automatic next_cycle();
    @(posedge clk_74a);
    #1;
  endtask

  task automatic load_trace(output bit ok);
    int          fd;
    int          code;
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] b;
    int          c;
    int          v_count;
    string       line;
    v_count = 0;
    fd = $fopen("core_trace.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, " %c", kind);
        if (code != 1) break;
        a = '0;
        b = '0;
        c = 0;
        if (kind == "#") begin
          code = $fgets(line, fd);
        end else begin
          if (kind == "W" || kind == "R") code = $fscanf(fd, "%h %h", a, b);
          else if (kind == "S") code = $fscanf(fd, "%h", a);
          else code = $fscanf(fd, "%d %d %d", a, b, c);
          if (kind == "V") v_count++;
          rec_kind.push_back(kind);
          rec_a.push_back(a);
          rec_b.push_back(b);
          rec_c.push_back(c);
        end
      end
      $fclose(fd);
      limit_cycles = rec_kind.size() * 40 + v_count * frame_cycles * 2;
    end
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    next_cycle();
    bridge.addr    = addr;
    bridge.wr      = 1'b1;
    bridge.wr_data = data;
    next_cycle();
    bridge.wr = 1'b0;
    repeat (3) next_cycle();
  endtask

  // result is due 4 cycles after the strobe, address held meanwhile
  task automatic bridge_read(input logic [31:0] addr, input logic [31:0] expected);
    next_cycle();
    bridge.addr = addr;
    bridge.rd   = 1'b1;
    next_cycle();
    bridge.rd = 1'b0;
    repeat (3) next_cycle();
    check_kind = "R";
    exp_value  = expected;
    check_stb  = 1'b1;
    next_cycle();
    check_stb = 1'b0;
  endtask

  task automatic check_settings(input logic [31:0] expected);
    next_cycle();
    check_kind = "S";
    exp_value  = expected;
    check_stb  = 1'b1;
    next_cycle();
    check_stb = 1'b0;
  endtask

  // 8 lines of 20 active and 12 blank cycles, vsync on every 4th line
  task automatic run_frame(input int orient, input int vert, input int bit_exp);
    bridge_write(bridge_pkg::addr_orientation, 32'(orient));
    is_vertical  = vert[0];
    slot_bit     = bit_exp[0];
    video_active = 1'b1;
    for (int l = 0; l < frame_lines; l++) begin
      for (int c = 0; c < line_cycles; c++) begin
        video_in.hblank = (c >= active_cycles);
        video_in.vblank = (l == frame_lines - 1);
        video_in.hsync  = (c >= 24 && c < 28);
        video_in.vsync  = (l % 4 == 3);
        video_in.rgb    = (c < active_cycles) ? 24'($random(seed)) : 24'h0;
        next_cycle();
      end
    end
    video_in = '{hblank: 1'b1, vblank: 1'b1, hsync: 1'b0, vsync: 1'b0, rgb: 24'h0};
    repeat (tail_cycles) next_cycle();
    video_active = 1'b0;
    next_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    bit ok;
    pll_core_locked = 1'b0;
    bridge          = '0;
    video_in        = '{hblank: 1'b1, vblank: 1'b1, hsync: 1'b0, vsync: 1'b0, rgb: 24'h0};
    is_vertical     = 1'b0;
    check_stb       = 1'b0;
    check_kind      = "-";
    test_name       = '0;
    exp_value       = '0;
    video_active    = 1'b0;
    slot_bit        = 1'b0;
    done            = 1'b0;
    seed            = 32'h12d30249;
    load_trace(ok);
    if (!ok) begin
      $display("could not open the trace file core_trace.txt");
      $display("=== FAIL ===");
      $finish;
    end else begin
      trace_loaded = 1'b1;
      repeat (3) @(posedge clk_74a);
      #1;
      pll_core_locked = 1'b1;
      next_cycle();
      for (int i = 0; i < rec_kind.size(); i++) begin
        case (rec_kind[i])
          "W": bridge_write(rec_a[i], rec_b[i]);
          "R": begin
            $sformat(test_name, "read_%0d", i);
            bridge_read(rec_a[i], rec_b[i]);
          end
          "S": begin
            $sformat(test_name, "settings_%0d", i);
            check_settings(rec_a[i]);
          end
          default: begin
            $sformat(test_name, "frame_%0d", i);
            run_frame(int'(rec_a[i]), int'(rec_b[i]), rec_c[i]);
          end
        endcase
      end
      while (external_reset) next_cycle();
      done = 1'b1;
      repeat (2) next_cycle();
      if (tests_failed == 0 && tests_run > 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

  // watchdog, sized from the trace length
  initial begin
    wait (trace_loaded);
    #(limit_cycles * 8);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- video_conditioner.sv
////////////////////////////////////////////////////////////
// turns core blanking and sync levels into scaler video:
// data enable, sync pulses and the orientation slot word
////////////////////////////////////////////////////////////

module video_conditioner (
  input  logic                     clk_74a,
  input  logic                     pll_core_locked,
  input  video_pkg::video_in_t     video_in,
  input  logic                     is_vertical,
  input  bridge_pkg::orientation_e orientation,
  output video_pkg::video_out_t    video_out
);

  logic [video_pkg::hs_delay_width-1:0] hs_delay;
  logic                                 de_prev;
  logic                                 hs_prev;
  logic                                 vs_prev;
  logic                                 de;
  logic                                 orient_bit;
  logic [23:0]                          slot_rgb;

  assign de = ~(video_in.hblank | video_in.vblank);

  // any vertical orientation selects the second slot
  always_comb begin
    case (orientation)
      bridge_pkg::orient_auto:     orient_bit = is_vertical;
      bridge_pkg::orient_vertical: orient_bit = 1'b1;
      default:                     orient_bit = 1'b0;
    endcase
  end

  always_comb begin
    slot_rgb = '0;
    slot_rgb[video_pkg::slot_orientation_bit] = orient_bit;
  end

  ////////////////////////////////////////////////////////////
  // output register stage

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      video_out <= '0;
      hs_delay  <= '0;
      de_prev   <= 1'b0;
      hs_prev   <= 1'b0;
      vs_prev   <= 1'b0;
    end else begin
      video_out.de <= de;
      // vs on the rising edge of the core vsync
      video_out.vs <= video_in.vsync && !vs_prev;
      video_out.hs <= (hs_delay == video_pkg::hs_delay_width'(1));

      if (de) begin
        video_out.rgb <= video_in.rgb;
      end else if (de_prev) begin
        // first blank cycle after active video
        video_out.rgb <= slot_rgb;
      end else begin
        video_out.rgb <= '0;
      end

      // hs held back so it never lands on the vs pulse
      if (video_in.hsync && !hs_prev) begin
        hs_delay <= video_pkg::hs_delay_start;
      end else if (hs_delay != '0) begin
        hs_delay <= hs_delay - 1'b1;
      end

      de_prev <= de;
      hs_prev <= video_in.hsync;
      vs_prev <= video_in.vsync;
    end
  end

endmodule

//--- video_pkg.sv
////////////////////////////////////////////////////////////
// video records between the core and the scaler output
// plus the sync delay and slot word constants
////////////////////////////////////////////////////////////

package video_pkg;

  // levels straight from the core
  typedef struct packed {
    logic        hblank;
    logic        vblank;
    logic        hsync;
    logic        vsync;
    logic [23:0] rgb;
  } video_in_t;

  // scaler side, sync as single cycle pulses
  typedef struct packed {
    logic        de;
    logic        hs;
    logic        vs;
    logic [23:0] rgb;
  } video_out_t;

  // hs is pushed away from vs by this many cycles
  localparam int                  hs_delay_width = 3;
  localparam logic [hs_delay_width-1:0] hs_delay_start = 3'd7;

  // slot word bit that carries the orientation
  localparam int slot_orientation_bit = 13;

endpackage
